// File: src/eth_mmio_pkg.sv
`default_nettype none

package eth_mmio_pkg;

    // Bus geometry
    localparam int ADDR_W    = 16;
    localparam int DATA_W    = 64;
    localparam int REG_IDX_W = 3;
    // Byte offset bits below the register index
    localparam int ADDR_LSB  = 3;

    // One payload beat fits beside the flag byte of a 64-bit word
    localparam int BEAT_BYTES = 7;
    localparam int BEAT_W     = BEAT_BYTES * 8;

    localparam logic [REG_IDX_W-1:0] REG_SRC_MAC    = 3'd0;
    localparam logic [REG_IDX_W-1:0] REG_TX_HDR     = 3'd1;
    localparam logic [REG_IDX_W-1:0] REG_TX_DATA    = 3'd2;
    localparam logic [REG_IDX_W-1:0] REG_RX_SRC_MAC = 3'd3;
    localparam logic [REG_IDX_W-1:0] REG_RX_HDR     = 3'd4;
    localparam logic [REG_IDX_W-1:0] REG_RX_DATA    = 3'd5;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    // Header word of reg 1 and reg 4
    localparam int HDR_TYPE_LSB = 48;
    localparam int HDR_DMAC_LSB = 0;

    typedef struct packed {
        logic              arvalid;
        logic [ADDR_W-1:0] araddr;
        logic              rready;
        logic              awvalid;
        logic [ADDR_W-1:0] awaddr;
        logic              wvalid;
        logic [DATA_W-1:0] wdata;
        logic              bready;
    } axil_req_t;

    typedef struct packed {
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        logic [1:0]        rresp;
        logic              awready;
        logic              wready;
        logic              bvalid;
        logic [1:0]        bresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
    } eth_hdr_t;

    typedef struct packed {
        logic [BEAT_W-1:0]     data;
        logic [BEAT_BYTES-1:0] keep;
        logic                  last;
    } eth_beat_t;

    typedef struct packed {
        logic              valid;
        logic              last;
        logic [2:0]        zero;
        logic [2:0]        size;
        logic [BEAT_W-1:0] data;
    } frame_fields_t;

    // Data words of reg 2 and reg 5
    typedef union packed {
        logic [DATA_W-1:0] raw;
        frame_fields_t     frame;
    } frame_word_t;

endpackage

`default_nettype wire

// File: src/axil_slave_port.sv
`timescale 1ns/1ps
`default_nettype none

module axil_slave_port import eth_mmio_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire axil_req_t      bus_req,
    output axil_rsp_t           bus_rsp,
    output logic                rd_strobe,
    output logic [REG_IDX_W-1:0] rd_idx,
    output logic                rd_bad,
    input  wire [DATA_W-1:0]    rd_word,
    input  wire                 rd_err,
    output logic                wr_strobe,
    output logic [REG_IDX_W-1:0] wr_idx,
    output logic                wr_bad,
    output logic [DATA_W-1:0]   wr_word,
    input  wire                 wr_hold
);

    function automatic logic [REG_IDX_W-1:0] addr_idx(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_LSB +: REG_IDX_W];
    endfunction

    // Anything above the register window is out of range
    function automatic logic addr_bad(input logic [ADDR_W-1:0] addr);
        return |addr[ADDR_W-1:ADDR_LSB+REG_IDX_W];
    endfunction

    logic                 ar_pend;
    logic [REG_IDX_W-1:0] ar_idx;
    logic                 ar_bad;
    logic                 rvalid;
    logic [DATA_W-1:0]    rdata;
    logic [1:0]           rresp;

    logic                 aw_pend;
    logic [REG_IDX_W-1:0] aw_idx;
    logic                 aw_bad;
    logic                 w_pend;
    logic [DATA_W-1:0]    w_data;
    logic                 bvalid;
    logic [1:0]           bresp;

    wire r_free  = !rvalid || bus_req.rready;
    wire b_free  = !bvalid || bus_req.bready;
    wire ar_hs   = bus_req.arvalid && bus_rsp.arready;
    wire aw_hs   = bus_req.awvalid && !aw_pend;
    wire w_hs    = bus_req.wvalid && !w_pend;

    assign rd_strobe = ar_pend && r_free;
    assign rd_idx    = ar_idx;
    assign rd_bad    = ar_bad;

    assign wr_strobe = aw_pend && w_pend && b_free && !wr_hold;
    assign wr_idx    = aw_idx;
    assign wr_bad    = aw_bad;
    assign wr_word   = w_data;

    // Buffer slot frees in the same cycle its strobe goes out
    assign bus_rsp.arready = !ar_pend || r_free;
    assign bus_rsp.rvalid  = rvalid;
    assign bus_rsp.rdata   = rdata;
    assign bus_rsp.rresp   = rresp;
    assign bus_rsp.awready = !aw_pend;
    assign bus_rsp.wready  = !w_pend;
    assign bus_rsp.bvalid  = bvalid;
    assign bus_rsp.bresp   = bresp;

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_pend <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (ar_hs)
                ar_pend <= 1'b1;
            else if (rd_strobe)
                ar_pend <= 1'b0;

            if (rd_strobe)
                rvalid <= 1'b1;
            else if (bus_req.rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            ar_idx <= addr_idx(bus_req.araddr);
            ar_bad <= addr_bad(bus_req.araddr);
        end
        if (rd_strobe) begin
            rdata <= rd_word;
            rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (aw_hs)
                aw_pend <= 1'b1;
            else if (wr_strobe)
                aw_pend <= 1'b0;

            if (w_hs)
                w_pend <= 1'b1;
            else if (wr_strobe)
                w_pend <= 1'b0;

            if (wr_strobe)
                bvalid <= 1'b1;
            else if (bus_req.bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_idx <= addr_idx(bus_req.awaddr);
            aw_bad <= addr_bad(bus_req.awaddr);
        end
        if (w_hs)
            w_data <= bus_req.wdata;
        // Indices 6 and 7 have no register behind them
        if (wr_strobe)
            bresp <= (aw_bad || aw_idx > REG_RX_DATA) ? RESP_SLVERR : RESP_OKAY;
    end

    assert property (@(posedge clk) disable iff (rst) rd_strobe |=> rvalid);

    // A stalled response keeps its contents
    assert property (@(posedge clk) disable iff (rst)
        (rvalid && !bus_req.rready) |=> (rvalid && $stable(rdata) && $stable(rresp)));

    assert property (@(posedge clk) disable iff (rst)
        (bvalid && !bus_req.bready) |=> (bvalid && $stable(bresp)));

endmodule

`default_nettype wire

// File: src/mmio_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_regs import eth_mmio_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 rd_strobe,
    input  wire [REG_IDX_W-1:0] rd_idx,
    input  wire                 rd_bad,
    output logic [DATA_W-1:0]   rd_word,
    output logic                rd_err,
    input  wire                 wr_strobe,
    input  wire [REG_IDX_W-1:0] wr_idx,
    input  wire                 wr_bad,
    input  wire [DATA_W-1:0]    wr_word,
    output logic                wr_hold,
    output logic                rx_pop,
    input  wire frame_word_t    rx_word,
    input  wire eth_hdr_t       rx_seen,
    output logic                tx_push,
    output frame_word_t         tx_word,
    output eth_hdr_t            tx_cfg,
    input  wire                 tx_free
);

    logic [47:0]       src_mac;
    logic [DATA_W-1:0] tx_hdr_word;
    logic [DATA_W-1:0] rx_hdr_word;

    wire wr_tx = !wr_bad && wr_idx == REG_TX_DATA;

    // Reg 2 writes wait for the transmit side
    assign wr_hold = wr_tx && !tx_free;
    assign tx_push = wr_strobe && wr_tx;
    assign tx_word = frame_word_t'(wr_word);
    assign rx_pop  = rd_strobe && !rd_bad && rd_idx == REG_RX_DATA;

    assign tx_cfg.dest_mac  = tx_hdr_word[HDR_DMAC_LSB +: 48];
    assign tx_cfg.src_mac   = src_mac;
    assign tx_cfg.ethertype = tx_hdr_word[HDR_TYPE_LSB +: 16];

    always_comb begin
        rx_hdr_word = '0;
        rx_hdr_word[HDR_DMAC_LSB +: 48] = rx_seen.dest_mac;
        rx_hdr_word[HDR_TYPE_LSB +: 16] = rx_seen.ethertype;
    end

    always_comb begin
        rd_word = '0;
        rd_err  = rd_bad;
        if (!rd_bad) begin
            case (rd_idx)
                REG_SRC_MAC:    rd_word = {16'b0, src_mac};
                REG_TX_HDR:     rd_word = tx_hdr_word;
                REG_RX_SRC_MAC: rd_word = {16'b0, rx_seen.src_mac};
                REG_RX_HDR:     rd_word = rx_hdr_word;
                REG_RX_DATA:    rd_word = rx_word.raw;
                // Write-only data port and unused indices
                default:        rd_err = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            src_mac     <= '0;
            tx_hdr_word <= '0;
        end else if (wr_strobe && !wr_bad) begin
            if (wr_idx == REG_SRC_MAC)
                src_mac <= wr_word[47:0];
            if (wr_idx == REG_TX_HDR)
                tx_hdr_word <= wr_word;
        end
    end

endmodule

`default_nettype wire

// File: src/eth_rx_reader.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_reader import eth_mmio_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire            rx_pop,
    output frame_word_t    rx_word,
    output eth_hdr_t       rx_seen,
    input  wire            rx_hdr_valid,
    input  wire eth_hdr_t  rx_hdr,
    output logic           rx_hdr_ready,
    input  wire            rx_beat_valid,
    input  wire eth_beat_t rx_beat,
    output logic           rx_beat_ready
);

    // Byte count of a thermometer keep
    function automatic logic [2:0] keep_size(input logic [BEAT_BYTES-1:0] keep);
        logic [2:0] n;
        n = '0;
        for (int i = 0; i < BEAT_BYTES; i++)
            n = n + 3'(keep[i]);
        return n;
    endfunction

    logic in_frame;

    // A frame opens with its header, beats may only follow
    assign rx_hdr_ready  = rx_pop && !in_frame && rx_hdr_valid;
    assign rx_beat_ready = rx_pop && rx_beat_valid && (in_frame || rx_hdr_valid);

    always_comb begin
        rx_word = '0;
        if (rx_beat_ready) begin
            rx_word.frame.valid = 1'b1;
            rx_word.frame.last  = rx_beat.last;
            rx_word.frame.size  = keep_size(rx_beat.keep);
            rx_word.frame.data  = rx_beat.data;
        end else if (rx_hdr_ready) begin
            // Header taken, payload not yet there
            rx_word.frame.valid = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            in_frame <= 1'b0;
        else if (rx_beat_ready)
            in_frame <= !rx_beat.last;
        else if (rx_hdr_ready)
            in_frame <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rx_hdr_ready)
            rx_seen <= rx_hdr;
    end

    assert property (@(posedge clk) disable iff (rst)
        rx_beat_ready |-> ((rx_beat.keep + 7'd1) & rx_beat.keep) == '0);

endmodule

`default_nettype wire

// File: src/eth_tx_writer.sv
`timescale 1ns/1ps
`default_nettype none

module eth_tx_writer import eth_mmio_pkg::*; (
    input  wire              clk,
    input  wire              rst,
    input  wire              tx_push,
    input  wire frame_word_t tx_word,
    input  wire eth_hdr_t    tx_cfg,
    output logic             tx_free,
    output logic             tx_hdr_valid,
    output eth_hdr_t         tx_hdr,
    input  wire              tx_hdr_ready,
    output logic             tx_beat_valid,
    output eth_beat_t        tx_beat,
    input  wire              tx_beat_ready
);

    // Low size bytes set, lowest byte first
    function automatic logic [BEAT_BYTES-1:0] size_keep(input logic [2:0] size);
        logic [BEAT_BYTES:0] ones;
        ones = (8'd1 << size) - 8'd1;
        return ones[BEAT_BYTES-1:0];
    endfunction

    logic in_frame;

    // Room for a new word once header and beat are both gone
    assign tx_free = !tx_hdr_valid && !tx_beat_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame      <= 1'b0;
            tx_hdr_valid  <= 1'b0;
            tx_beat_valid <= 1'b0;
        end else if (tx_push) begin
            in_frame      <= !tx_word.frame.last;
            tx_beat_valid <= 1'b1;
            if (!in_frame)
                tx_hdr_valid <= 1'b1;
        end else begin
            if (tx_hdr_ready)
                tx_hdr_valid <= 1'b0;
            if (tx_beat_ready)
                tx_beat_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (tx_push) begin
            tx_beat.data <= tx_word.frame.data;
            tx_beat.keep <= size_keep(tx_word.frame.size);
            tx_beat.last <= tx_word.frame.last;
            if (!in_frame)
                tx_hdr <= tx_cfg;
        end
    end

    assert property (@(posedge clk) disable iff (rst) tx_push |-> tx_free);

endmodule

`default_nettype wire

// File: src/eth_mmio_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module eth_mmio_bridge import eth_mmio_pkg::*; (
    input  wire            clk,
    input  wire            rst,
    input  wire axil_req_t bus_req,
    output axil_rsp_t      bus_rsp,
    input  wire            rx_hdr_valid,
    input  wire eth_hdr_t  rx_hdr,
    output logic           rx_hdr_ready,
    input  wire            rx_beat_valid,
    input  wire eth_beat_t rx_beat,
    output logic           rx_beat_ready,
    output logic           tx_hdr_valid,
    output eth_hdr_t       tx_hdr,
    input  wire            tx_hdr_ready,
    output logic           tx_beat_valid,
    output eth_beat_t      tx_beat,
    input  wire            tx_beat_ready
);

    logic                 rd_strobe;
    logic [REG_IDX_W-1:0] rd_idx;
    logic                 rd_bad;
    logic [DATA_W-1:0]    rd_word;
    logic                 rd_err;
    logic                 wr_strobe;
    logic [REG_IDX_W-1:0] wr_idx;
    logic                 wr_bad;
    logic [DATA_W-1:0]    wr_word;
    logic                 wr_hold;
    logic                 rx_pop;
    frame_word_t          rx_word;
    eth_hdr_t             rx_seen;
    logic                 tx_push;
    frame_word_t          tx_word;
    eth_hdr_t             tx_cfg;
    logic                 tx_free;

    axil_slave_port u_port (
        .clk       (clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .rd_strobe (rd_strobe),
        .rd_idx    (rd_idx),
        .rd_bad    (rd_bad),
        .rd_word   (rd_word),
        .rd_err    (rd_err),
        .wr_strobe (wr_strobe),
        .wr_idx    (wr_idx),
        .wr_bad    (wr_bad),
        .wr_word   (wr_word),
        .wr_hold   (wr_hold)
    );

    mmio_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .rd_strobe (rd_strobe),
        .rd_idx    (rd_idx),
        .rd_bad    (rd_bad),
        .rd_word   (rd_word),
        .rd_err    (rd_err),
        .wr_strobe (wr_strobe),
        .wr_idx    (wr_idx),
        .wr_bad    (wr_bad),
        .wr_word   (wr_word),
        .wr_hold   (wr_hold),
        .rx_pop    (rx_pop),
        .rx_word   (rx_word),
        .rx_seen   (rx_seen),
        .tx_push   (tx_push),
        .tx_word   (tx_word),
        .tx_cfg    (tx_cfg),
        .tx_free   (tx_free)
    );

    eth_rx_reader u_rx (
        .clk           (clk),
        .rst           (rst),
        .rx_pop        (rx_pop),
        .rx_word       (rx_word),
        .rx_seen       (rx_seen),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr        (rx_hdr),
        .rx_hdr_ready  (rx_hdr_ready),
        .rx_beat_valid (rx_beat_valid),
        .rx_beat       (rx_beat),
        .rx_beat_ready (rx_beat_ready)
    );

    eth_tx_writer u_tx (
        .clk           (clk),
        .rst           (rst),
        .tx_push       (tx_push),
        .tx_word       (tx_word),
        .tx_cfg        (tx_cfg),
        .tx_free       (tx_free),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr        (tx_hdr),
        .tx_hdr_ready  (tx_hdr_ready),
        .tx_beat_valid (tx_beat_valid),
        .tx_beat       (tx_beat),
        .tx_beat_ready (tx_beat_ready)
    );

endmodule

`default_nettype wire

// File: tests/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk
);

    // 100 ns period
    localparam int HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

// File: tests/tb_eth_mmio_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eth_mmio_bridge import eth_mmio_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int DRIVE_DELAY    = 10;
    localparam int RX_BEATS       = 4;

    logic      clk;
    logic      rst;
    axil_req_t bus_req;
    axil_rsp_t bus_rsp;
    logic      rx_hdr_valid;
    eth_hdr_t  rx_hdr;
    logic      rx_hdr_ready;
    logic      rx_beat_valid;
    eth_beat_t rx_beat;
    logic      rx_beat_ready;
    logic      tx_hdr_valid;
    eth_hdr_t  tx_hdr;
    logic      tx_hdr_ready;
    logic      tx_beat_valid;
    eth_beat_t tx_beat;
    logic      tx_beat_ready;

    // Expected transmit traffic, consumed by the monitor
    eth_hdr_t  exp_hdr_q[$];
    eth_beat_t exp_beat_q[$];

    int errors = 0;
    int checks = 0;

    clk_gen u_clk (
        .clk (clk)
    );

    eth_mmio_bridge uut (
        .clk           (clk),
        .rst           (rst),
        .bus_req       (bus_req),
        .bus_rsp       (bus_rsp),
        .rx_hdr_valid  (rx_hdr_valid),
        .rx_hdr        (rx_hdr),
        .rx_hdr_ready  (rx_hdr_ready),
        .rx_beat_valid (rx_beat_valid),
        .rx_beat       (rx_beat),
        .rx_beat_ready (rx_beat_ready),
        .tx_hdr_valid  (tx_hdr_valid),
        .tx_hdr        (tx_hdr),
        .tx_hdr_ready  (tx_hdr_ready),
        .tx_beat_valid (tx_beat_valid),
        .tx_beat       (tx_beat),
        .tx_beat_ready (tx_beat_ready)
    );

    function automatic logic [DATA_W-1:0] rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [ADDR_W-1:0] reg_addr(input int idx);
        return ADDR_W'(idx * 8);
    endfunction

    // Read word of reg 5: flag byte on top, payload below
    function automatic frame_word_t pack_rx_word(input eth_beat_t beat, input logic valid,
                                                 input logic last);
        frame_word_t w;
        int          n;
        w.raw = '0;
        n = 0;
        if (valid) begin
            // Thermometer keep, so the size is the highest kept byte plus one
            for (int i = 0; i < BEAT_BYTES; i++) begin
                if (beat.keep[i])
                    n = i + 1;
            end
            w.frame.valid = 1'b1;
            w.frame.last  = last;
            w.frame.size  = n[2:0];
            w.frame.data  = beat.data;
        end
        return w;
    endfunction

    function automatic eth_beat_t expect_tx_beat(input frame_word_t word);
        eth_beat_t b;
        b.data = word.frame.data;
        for (int i = 0; i < BEAT_BYTES; i++)
            b.keep[i] = (i < word.frame.size);
        b.last = word.frame.last;
        return b;
    endfunction

    task automatic check_word(input string name, input frame_word_t exp, input frame_word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp.raw, act.raw);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_hdr(input string name, input eth_hdr_t exp, input eth_hdr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_beat(input string name, input eth_beat_t exp, input eth_beat_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("Result: %0d errors in %0d checks", errors, checks);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    endtask

    task automatic wait_expired(input string what);
        errors++;
        $display("Timed out waiting for %s", what);
        finish_run();
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                            output logic [1:0] resp);
        int   n;
        logic done;
        bus_req.arvalid = 1'b1;
        bus_req.araddr  = addr;
        bus_req.rready  = 1'b1;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = bus_rsp.arready;
            n++;
            if (!done && n > TIMEOUT_CYCLES)
                wait_expired("read address handshake");
            @(posedge clk);
            #DRIVE_DELAY;
        end
        bus_req.arvalid = 1'b0;
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = bus_rsp.rvalid;
            data = bus_rsp.rdata;
            resp = bus_rsp.rresp;
            n++;
            if (!done && n > TIMEOUT_CYCLES)
                wait_expired("read data");
            @(posedge clk);
            #DRIVE_DELAY;
        end
        bus_req.rready = 1'b0;
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             output logic [1:0] resp);
        int   n;
        logic aw_done;
        logic w_done;
        logic b_done;
        bus_req.awvalid = 1'b1;
        bus_req.awaddr  = addr;
        bus_req.wvalid  = 1'b1;
        bus_req.wdata   = data;
        bus_req.bready  = 1'b1;
        n = 0;
        aw_done = 1'b0;
        w_done = 1'b0;
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            if (bus_req.awvalid && bus_rsp.awready)
                aw_done = 1'b1;
            if (bus_req.wvalid && bus_rsp.wready)
                w_done = 1'b1;
            n++;
            if (!(aw_done && w_done) && n > TIMEOUT_CYCLES)
                wait_expired("write address and data handshakes");
            @(posedge clk);
            #DRIVE_DELAY;
            if (aw_done)
                bus_req.awvalid = 1'b0;
            if (w_done)
                bus_req.wvalid = 1'b0;
        end
        n = 0;
        b_done = 1'b0;
        while (!b_done) begin
            @(negedge clk);
            b_done = bus_rsp.bvalid;
            resp = bus_rsp.bresp;
            n++;
            if (!b_done && n > TIMEOUT_CYCLES)
                wait_expired("write response");
            @(posedge clk);
            #DRIVE_DELAY;
        end
        bus_req.bready = 1'b0;
    endtask

    // One header per frame, then one beat per word
    task automatic send_frame(input eth_hdr_t cfg, input int nwords);
        frame_word_t w;
        logic [1:0]  resp;
        exp_hdr_q.push_back(cfg);
        for (int i = 0; i < nwords; i++) begin
            w.raw = rand64();
            w.frame.valid = 1'b1;
            w.frame.last  = (i == nwords - 1);
            w.frame.zero  = '0;
            exp_beat_q.push_back(expect_tx_beat(w));
            bus_write(reg_addr(2), w.raw, resp);
            check_resp("tx data write", RESP_OKAY, resp);
        end
    endtask

    task automatic drain_tx();
        int n;
        n = 0;
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            n++;
            if (n > TIMEOUT_CYCLES)
                wait_expired("transmit side to drain");
            @(posedge clk);
            #DRIVE_DELAY;
        end
        if (tx_hdr_valid || tx_beat_valid) begin
            errors++;
            $display("Transmit valid still high after all expected transfers");
        end
    endtask

    // Random stalls on the transmit side, every handshake checked in order
    initial begin : tx_monitor
        tx_hdr_ready = 1'b0;
        tx_beat_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && tx_hdr_valid && tx_hdr_ready) begin
                if (exp_hdr_q.size() == 0) begin
                    errors++;
                    $display("Transmit header sent while none was expected");
                end else begin
                    check_hdr("tx header", exp_hdr_q.pop_front(), tx_hdr);
                end
            end
            if (!rst && tx_beat_valid && tx_beat_ready) begin
                if (exp_beat_q.size() == 0) begin
                    errors++;
                    $display("Transmit beat sent while none was expected");
                end else begin
                    check_beat("tx beat", exp_beat_q.pop_front(), tx_beat);
                end
            end
            @(posedge clk);
            #DRIVE_DELAY;
            tx_hdr_ready  = ($urandom % 4) != 0;
            tx_beat_ready = ($urandom % 3) != 0;
        end
    end

    // Receive source drops valid once its item is taken
    initial begin : rx_feeder
        logic hdr_taken;
        logic beat_taken;
        forever begin
            @(negedge clk);
            hdr_taken  = rx_hdr_valid && rx_hdr_ready;
            beat_taken = rx_beat_valid && rx_beat_ready;
            @(posedge clk);
            #DRIVE_DELAY;
            if (hdr_taken)
                rx_hdr_valid = 1'b0;
            if (beat_taken)
                rx_beat_valid = 1'b0;
        end
    end

    initial begin : main_flow
        logic [DATA_W-1:0] rdata;
        logic [DATA_W-1:0] r;
        logic [1:0]        resp;
        logic [DATA_W-1:0] mac_word;
        logic [DATA_W-1:0] hdr_word;
        eth_hdr_t          cfg;
        eth_hdr_t          rx_offer;
        eth_beat_t         rx_beats[RX_BEATS];
        int                n;

        void'($urandom(65));
        rst           = 1'b1;
        bus_req       = '0;
        rx_hdr_valid  = 1'b0;
        rx_hdr        = '0;
        rx_beat_valid = 1'b0;
        rx_beat       = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        // Idle state after reset
        @(negedge clk);
        checks++;
        if (bus_rsp.rvalid || bus_rsp.bvalid || tx_hdr_valid || tx_beat_valid ||
            rx_hdr_ready || rx_beat_ready) begin
            errors++;
            $display("A valid or ready output is high after reset");
        end
        @(posedge clk);
        #DRIVE_DELAY;
        bus_read(reg_addr(0), rdata, resp);
        check_resp("reset reg 0 resp", RESP_OKAY, resp);
        check_word("reset reg 0", '0, rdata);

        // Configuration readback, low address bits ignored
        mac_word = rand64();
        bus_write(16'h0005, mac_word, resp);
        check_resp("reg 0 write", RESP_OKAY, resp);
        bus_read(16'h0003, rdata, resp);
        check_resp("reg 0 read", RESP_OKAY, resp);
        check_word("reg 0 readback", {16'h0, mac_word[47:0]}, rdata);
        hdr_word = rand64();
        bus_write(16'h0008, hdr_word, resp);
        check_resp("reg 1 write", RESP_OKAY, resp);
        bus_read(16'h000f, rdata, resp);
        check_resp("reg 1 read", RESP_OKAY, resp);
        check_word("reg 1 readback", hdr_word, rdata);

        // Transmit two frames
        cfg.dest_mac  = hdr_word[47:0];
        cfg.src_mac   = mac_word[47:0];
        cfg.ethertype = hdr_word[63:48];
        send_frame(cfg, 5);
        send_frame(cfg, 3);
        drain_tx();

        // Receive one frame through reg 5
        r = rand64();
        rx_offer.dest_mac  = r[47:0];
        rx_offer.ethertype = r[63:48];
        r = rand64();
        rx_offer.src_mac = r[47:0];
        for (int i = 0; i < RX_BEATS; i++) begin
            r = rand64();
            n = $urandom_range(7, 1);
            rx_beats[i].data = r[BEAT_W-1:0];
            rx_beats[i].keep = 7'h7f >> (7 - n);
            rx_beats[i].last = (i == RX_BEATS - 1);
        end
        rx_hdr = rx_offer;
        rx_hdr_valid = 1'b1;
        for (int i = 0; i < RX_BEATS; i++) begin
            rx_beat = rx_beats[i];
            rx_beat_valid = 1'b1;
            bus_read(reg_addr(5), rdata, resp);
            check_resp("rx data resp", RESP_OKAY, resp);
            check_word("rx data word", pack_rx_word(rx_beats[i], 1'b1, rx_beats[i].last), rdata);
        end
        bus_read(reg_addr(5), rdata, resp);
        check_resp("rx empty resp", RESP_OKAY, resp);
        check_word("rx empty word", pack_rx_word('0, 1'b0, 1'b0), rdata);
        bus_read(reg_addr(3), rdata, resp);
        check_word("reg 3 rx source", {16'h0, rx_offer.src_mac}, rdata);
        bus_read(reg_addr(4), rdata, resp);
        check_word("reg 4 rx header", {rx_offer.ethertype, rx_offer.dest_mac}, rdata);

        // Error responses
        bus_read(reg_addr(2), rdata, resp);
        check_resp("read reg 2", RESP_SLVERR, resp);
        bus_read(reg_addr(6), rdata, resp);
        check_resp("read reg 6", RESP_SLVERR, resp);
        bus_read(reg_addr(7), rdata, resp);
        check_resp("read reg 7", RESP_SLVERR, resp);
        bus_write(reg_addr(6), rand64(), resp);
        check_resp("write reg 6", RESP_SLVERR, resp);
        bus_write(reg_addr(7), rand64(), resp);
        check_resp("write reg 7", RESP_SLVERR, resp);
        bus_read(16'h0040, rdata, resp);
        check_resp("read bit 6 address", RESP_SLVERR, resp);
        bus_read(16'h8028, rdata, resp);
        check_resp("read bit 15 address", RESP_SLVERR, resp);
        bus_write(16'h0040, rand64(), resp);
        check_resp("write bit 6 address", RESP_SLVERR, resp);
        bus_write(16'h0050, rand64(), resp);
        check_resp("write high reg 2 address", RESP_SLVERR, resp);

        // Receive registers and reg 5 ignore writes
        bus_write(reg_addr(3), rand64(), resp);
        check_resp("write reg 3", RESP_OKAY, resp);
        bus_write(reg_addr(4), rand64(), resp);
        check_resp("write reg 4", RESP_OKAY, resp);
        bus_write(reg_addr(5), rand64(), resp);
        check_resp("write reg 5", RESP_OKAY, resp);
        bus_read(reg_addr(3), rdata, resp);
        check_word("reg 3 after write", {16'h0, rx_offer.src_mac}, rdata);
        bus_read(reg_addr(4), rdata, resp);
        check_word("reg 4 after write", {rx_offer.ethertype, rx_offer.dest_mac}, rdata);
        bus_read(reg_addr(0), rdata, resp);
        check_word("reg 0 unchanged", {16'h0, mac_word[47:0]}, rdata);
        bus_read(reg_addr(1), rdata, resp);
        check_word("reg 1 unchanged", hdr_word, rdata);

        drain_tx();
        finish_run();
    end

endmodule

`default_nettype wire

// File: eth_mmio_bridge.f
src/eth_mmio_pkg.sv
src/axil_slave_port.sv
src/mmio_regs.sv
src/eth_rx_reader.sv
src/eth_tx_writer.sv
src/eth_mmio_bridge.sv
tests/clk_gen.sv
tests/tb_eth_mmio_bridge.sv
